// ==== src/capi_cmd_pkg.sv ====
`default_nettype none

package capi_cmd_pkg;

  // Number of command sources feeding the arbiter.
  localparam int num_sources = 4;

  localparam int default_queue_depth = 4;
  localparam int default_max_credits = 8;

  // Sources in priority order, index 0 is served first.
  typedef enum logic [1:0] {
    src_wed     = 2'd0,
    src_write   = 2'd1,
    src_read    = 2'd2,
    src_restart = 2'd3
  } command_source_e;

  // Host command opcodes as carried on the command bus.
  typedef enum logic [12:0] {
    cmd_read_cl_na  = 13'h0A00,
    cmd_read_cl_s   = 13'h0A50,
    cmd_read_cl_m   = 13'h0A60,
    cmd_write_mi    = 13'h0D60,
    cmd_write_ms    = 13'h0D70,
    cmd_write_na    = 13'h0D00,
    cmd_restart     = 13'h0001
  } command_type_e;

  typedef enum logic [7:0] {
    rsp_done    = 8'h00,
    rsp_aerror  = 8'h01,
    rsp_derror  = 8'h03,
    rsp_nlock   = 8'h04,
    rsp_nres    = 8'h05,
    rsp_flushed = 8'h06,
    rsp_fault   = 8'h07,
    rsp_failed  = 8'h08,
    rsp_paged   = 8'h0A
  } response_code_e;

  // The upper two tag bits name the source that owns the command.
  typedef struct packed {
    command_type_e command;
    logic [7:0]    tag;
    logic [63:0]   address;
    logic [11:0]   size;
  } command_line_t;

  typedef struct packed {
    logic          valid;
    command_line_t line;
  } command_out_t;

  typedef struct packed {
    logic           valid;
    logic [7:0]     tag;
    response_code_e code;
    logic [8:0]     credits;
  } response_in_t;

  // Per-source strobes, bit positions follow command_source_e.
  typedef struct packed {
    logic [num_sources-1:0] ready;
    logic [num_sources-1:0] done;
    logic [num_sources-1:0] error;
  } source_status_t;

endpackage

`default_nettype wire

// ==== src/command_queue.sv ====
`default_nettype none

module command_queue
  import capi_cmd_pkg::*;
#(
  parameter int queue_depth = default_queue_depth
) (
  input  logic          clock,
  input  logic          rstn,
  input  logic          push,
  input  command_line_t push_line,
  input  logic          pop,
  output logic          request,
  output command_line_t head,
  output logic          full
);

  localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int count_width = $clog2(queue_depth + 1);

  command_line_t          mem [queue_depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  // A push into a full queue is dropped.
  assign do_push = push && !full;
  assign do_pop  = pop && request;

  assign request = (count != '0);
  assign full    = (count == count_width'(queue_depth));

  // The arbiter looks at the oldest entry directly.
  assign head = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_line;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr == ptr_width'(queue_depth - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr == ptr_width'(queue_depth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Push and pop in the same cycle leave the occupancy alone.
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/command_buffer_arbiter.sv ====
`default_nettype none

module command_buffer_arbiter
  import capi_cmd_pkg::*;
(
  input  logic                               clock,
  input  logic                               rstn,
  input  logic                               credit_ready,
  input  logic          [num_sources-1:0]    request,
  input  command_line_t [num_sources-1:0]    head,
  output logic                               issue,
  output logic          [num_sources-1:0]    ready,
  output command_out_t                       command_out
);

  logic [num_sources-1:0] grant;
  command_line_t          selected_line;

  // Fixed priority pick. The lowest index that requests wins, and only
  // while the host still holds a command credit for us.
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    if (credit_ready) begin
      for (int i = 0; i < num_sources; i++) begin
        if (request[i] && !found) begin
          grant[i] = 1'b1;
          found    = 1'b1;
        end
      end
    end
  end

  // The grant doubles as the pop strobe of the winning queue, so the
  // queue advances on the same edge that captures its head.
  assign ready = grant;
  assign issue = |grant;

  // Route the winning head line toward the output register.
  always_comb begin
    selected_line = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (grant[i]) begin
        selected_line = head[i];
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_out.valid <= 1'b0;
      command_out.line  <= '0;
    end else begin
      if (issue) begin
        command_out.valid <= 1'b1;
        command_out.line  <= selected_line;
      end else begin
        // Idle cycles drive a clean, all zero bus.
        command_out.valid <= 1'b0;
        command_out.line  <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/credit_tracker.sv ====
`default_nettype none

module credit_tracker
  import capi_cmd_pkg::*;
#(
  parameter int max_credits = default_max_credits
) (
  input  logic clock,
  input  logic rstn,
  input  logic issue,
  input  logic credit_return,
  output logic credit_ready
);

  localparam int count_width = $clog2(max_credits + 1);

  logic [count_width-1:0] credits;

  // Commands may go out as long as one credit is left.
  assign credit_ready = (credits != '0);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credits <= count_width'(max_credits);
    end else begin
      case ({issue, credit_return})
        2'b10: begin
          if (credits != '0) begin
            credits <= credits - 1'b1;
          end
        end
        2'b01: begin
          // The host never hands back more than it granted.
          if (credits != count_width'(max_credits)) begin
            credits <= credits + 1'b1;
          end
        end
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/response_decoder.sv ====
`default_nettype none

module response_decoder
  import capi_cmd_pkg::*;
(
  input  logic                   clock,
  input  logic                   rstn,
  input  response_in_t           response,
  output logic                   credit_return,
  output logic [num_sources-1:0] done,
  output logic [num_sources-1:0] error
);

  command_source_e owner;

  // The owning source sits in the top two bits of the tag.
  assign owner = command_source_e'(response.tag[7:6]);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credit_return <= 1'b0;
      done          <= '0;
      error         <= '0;
    end else begin
      credit_return <= 1'b0;
      done          <= '0;
      error         <= '0;
      if (response.valid) begin
        credit_return <= (response.credits != '0);
        // Anything other than a clean completion is reported as an error,
        // paged included, since the restart flow is not handled here.
        if (response.code == rsp_done) begin
          done[owner] <= 1'b1;
        end else begin
          error[owner] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/command_control.sv ====
`default_nettype none

module command_control
  import capi_cmd_pkg::*;
#(
  parameter int queue_depth = default_queue_depth,
  parameter int max_credits = default_max_credits
) (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic          [num_sources-1:0] push,
  input  command_line_t [num_sources-1:0] push_line,
  input  response_in_t                    response,
  output command_out_t                    command_out,
  output source_status_t                  status,
  output logic          [num_sources-1:0] full
);

  logic          [num_sources-1:0] request;
  command_line_t [num_sources-1:0] head;
  logic          [num_sources-1:0] ready;
  logic          [num_sources-1:0] done;
  logic          [num_sources-1:0] error;
  logic                            issue;
  logic                            credit_ready;
  logic                            credit_return;

  // One queue per source, popped by its own ready bit.
  for (genvar i = 0; i < num_sources; i++) begin : g_queue
    command_queue #(
      .queue_depth(queue_depth)
    ) i_command_queue (
      .clock    (clock),
      .rstn     (rstn),
      .push     (push[i]),
      .push_line(push_line[i]),
      .pop      (ready[i]),
      .request  (request[i]),
      .head     (head[i]),
      .full     (full[i])
    );
  end

  command_buffer_arbiter i_command_buffer_arbiter (
    .clock       (clock),
    .rstn        (rstn),
    .credit_ready(credit_ready),
    .request     (request),
    .head        (head),
    .issue       (issue),
    .ready       (ready),
    .command_out (command_out)
  );

  credit_tracker #(
    .max_credits(max_credits)
  ) i_credit_tracker (
    .clock        (clock),
    .rstn         (rstn),
    .issue        (issue),
    .credit_return(credit_return),
    .credit_ready (credit_ready)
  );

  response_decoder i_response_decoder (
    .clock        (clock),
    .rstn         (rstn),
    .response     (response),
    .credit_return(credit_return),
    .done         (done),
    .error        (error)
  );

  assign status.ready = ready;
  assign status.done  = done;
  assign status.error = error;

endmodule

`default_nettype wire

// ==== verif/command_control_sva.sv ====
`default_nettype none

module command_control_sva
  import capi_cmd_pkg::*;
(
  input wire logic           clock,
  input wire logic           rstn,
  input wire command_out_t   command_out,
  input wire source_status_t status,
  input wire logic           issue,
  input wire logic           credit_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // A registered command must come from exactly one granted source.
  valid_follows_one_grant: assert property (
    @(posedge clock) disable iff (!rstn)
    command_out.valid |-> $onehot($past(status.ready))
  ) else $error("command_out.valid without a single ready pulse before it");

  one_ready_per_cycle: assert property (
    @(posedge clock) disable iff (!rstn)
    $onehot0(status.ready)
  ) else $error("more than one ready bit set in one cycle");

  no_issue_without_credit: assert property (
    @(posedge clock) disable iff (!rstn)
    !credit_ready |-> !issue
  ) else $error("issue raised while credit_ready was low");

  // Held reset keeps the whole output side quiet.
  quiet_in_reset: assert property (
    @(posedge clock)
    !rstn |-> (!command_out.valid && status == '0)
  ) else $error("output active while rstn was low");

endmodule

bind command_control command_control_sva i_command_control_sva (
  .clock       (clock),
  .rstn        (rstn),
  .command_out (command_out),
  .status      (status),
  .issue       (issue),
  .credit_ready(credit_ready)
);

`default_nettype wire

// ==== verif/tb_command_control.sv ====
`default_nettype none

module tb_command_control
  import capi_cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int queue_depth = 4;
  localparam int max_credits = 8;
  // Six tests of at most 600 cycles each, plus margin.
  localparam int cycle_limit = 4000;

  logic                  clock;
  logic                  rstn;
  logic [3:0]            push;
  command_line_t [3:0]   push_line;
  response_in_t          response;
  command_out_t          command_out;
  source_status_t        status;
  logic [3:0]            full;

  // Reference model state.
  command_line_t  model_q [4][$];
  command_line_t  pending_line [4];
  logic [3:0]     pending_push;
  logic [3:0]     exp_done;
  logic [3:0]     exp_error;
  logic           ret_d1;
  logic           ret_d2;
  int             credits_prev;
  logic [7:0]     host_tags [$];
  logic [5:0]     seq [4];
  int             seed = 79238;
  int             errors = 0;
  int             cycles = 0;
  int             issued = 0;
  int             push_pct [4];
  int             host_pct;
  bit             host_on;
  bit             respond_once;
  int             base;
  string          test_name;
  command_type_e  kinds [7] = '{cmd_read_cl_na, cmd_read_cl_s, cmd_read_cl_m, cmd_write_mi,
                                cmd_write_ms, cmd_write_na, cmd_restart};
  response_code_e codes [9] = '{rsp_done, rsp_aerror, rsp_derror, rsp_nlock, rsp_nres,
                                rsp_flushed, rsp_fault, rsp_failed, rsp_paged};

  command_control #(
    .queue_depth(queue_depth),
    .max_credits(max_credits)
  ) i_command_control (
    .clock      (clock),
    .rstn       (rstn),
    .push       (push),
    .push_line  (push_line),
    .response   (response),
    .command_out(command_out),
    .status     (status),
    .full       (full)
  );

  always #5 clock = ~clock;

  function automatic int unsigned roll(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic command_line_t random_line(input int src);
    command_line_t line;
    line.command = kinds[roll(7)];
    line.tag     = {src[1:0], seq[src]};
    line.address = {$random(seed), $random(seed)};
    line.size    = 12'(roll(4096));
    seq[src]     = seq[src] + 1'b1;
    return line;
  endfunction

  task automatic report_mismatch(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
    errors++;
    $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error in %s: %s", test_name, what);
  endtask

  function automatic bit idle();
    bit empty;
    empty = (host_tags.size() == 0) && (credits_prev == max_credits) &&
            (pending_push == '0) && !command_out.valid;
    for (int i = 0; i < 4; i++) begin
      if (model_q[i].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic wait_idle();
    push_pct = '{default: 0};
    host_on  = 1'b1;
    host_pct = 30;
    @(posedge clock);
    while (!idle()) begin
      @(posedge clock);
    end
  endtask

  // Model step, once per falling edge. The model queues hold the state the
  // DUT had after the previous rising edge, which is what the grant used.
  always @(negedge clock) begin
    int            pick;
    int            src;
    command_line_t expected;
    logic [7:0]    tag;
    logic [3:0]    exp_ready;
    if (!rstn) begin
      for (int i = 0; i < 4; i++) begin
        model_q[i].delete();
      end
      host_tags.delete();
      credits_prev = max_credits;
      {ret_d1, ret_d2, pending_push, exp_done, exp_error} = '0;
      push     = '0;
      response = '0;
    end else begin
      pick = -1;
      for (int i = 3; i >= 0; i--) begin
        if (model_q[i].size() != 0) begin
          pick = i;
        end
      end
      if (command_out.valid) begin
        src = command_out.line.tag[7:6];
        if (credits_prev == 0) begin
          report_failure("a command issued while no credit was left");
        end
        if (src != pick) begin
          report_mismatch("issuing source", pick, src);
        end
        if (model_q[src].size() == 0) begin
          report_failure("a command issued from a source with nothing queued");
        end else begin
          expected = model_q[src].pop_front();
          if (command_out.line != expected) begin
            report_mismatch("command line", expected, command_out.line);
          end
        end
        host_tags.push_back(command_out.line.tag);
        issued++;
      end else if (pick >= 0 && credits_prev > 0) begin
        report_failure("a queued command stalled although credits were left");
      end
      credits_prev = credits_prev - (command_out.valid ? 1 : 0) + (ret_d2 ? 1 : 0);
      if (credits_prev > max_credits) begin
        credits_prev = max_credits;
      end else if (credits_prev < 0) begin
        credits_prev = 0;
      end
      if (status.done != exp_done) begin
        report_mismatch("done strobe", exp_done, status.done);
      end
      if (status.error != exp_error) begin
        report_mismatch("error strobe", exp_error, status.error);
      end
      for (int i = 0; i < 4; i++) begin
        if (pending_push[i]) begin
          model_q[i].push_back(pending_line[i]);
        end
        if (full[i] != (model_q[i].size() == queue_depth)) begin
          report_mismatch("full flag", model_q[i].size() == queue_depth, full[i]);
        end
      end
      // The pop strobe goes to the highest priority source that holds a
      // line, and only while a credit is left.
      exp_ready = '0;
      if (credits_prev > 0) begin
        for (int i = 3; i >= 0; i--) begin
          if (model_q[i].size() != 0) begin
            exp_ready    = '0;
            exp_ready[i] = 1'b1;
          end
        end
      end
      if (status.ready != exp_ready) begin
        report_mismatch("ready strobe", exp_ready, status.ready);
      end
      // Host side answers the oldest outstanding tag.
      response  = '0;
      exp_done  = '0;
      exp_error = '0;
      ret_d2    = ret_d1;
      ret_d1    = 1'b0;
      if (host_tags.size() != 0 && (respond_once || (host_on && roll(100) < host_pct))) begin
        tag              = host_tags.pop_front();
        response.valid   = 1'b1;
        response.tag     = tag;
        response.code    = (roll(2) == 0) ? rsp_done : codes[roll(9)];
        response.credits = 9'd1;
        if (response.code == rsp_done) begin
          exp_done[tag[7:6]] = 1'b1;
        end else begin
          exp_error[tag[7:6]] = 1'b1;
        end
        ret_d1       = 1'b1;
        respond_once = 1'b0;
      end
      push = '0;
      for (int i = 0; i < 4; i++) begin
        if (model_q[i].size() < queue_depth && roll(100) < push_pct[i]) begin
          push[i]      = 1'b1;
          push_line[i] = random_line(i);
        end
        pending_line[i] = push_line[i];
      end
      pending_push = push;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors counted before the timeout: %0d", errors);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    clock        = 1'b0;
    rstn         = 1'b0;
    push         = '0;
    push_line    = '0;
    response     = '0;
    push_pct     = '{default: 0};
    seq          = '{default: '0};
    host_on      = 1'b0;
    host_pct     = 0;
    respond_once = 1'b0;
    test_name    = "reset_state";
    repeat (4) @(negedge clock);
    rstn <= 1'b1;
    @(negedge clock);
    if (command_out.valid || status != '0 || full != '0) begin
      report_failure("outputs were not all low after reset");
    end
    // One push, its timing is enforced by the model step.
    @(posedge clock);
    push_pct[src_read] = 100;
    @(posedge clock);
    push_pct[src_read] = 0;
    wait_idle();
    if (issued != 1) begin
      report_mismatch("commands issued", 1, issued);
    end

    test_name = "order";
    push_pct  = '{30, 30, 30, 30};
    host_pct  = 40;
    repeat (300) @(posedge clock);
    wait_idle();

    // Credits run out first, then released slowly so priority decides.
    test_name = "priority";
    host_on   = 1'b0;
    push_pct  = '{50, 50, 50, 50};
    repeat (40) @(posedge clock);
    push_pct = '{default: 0};
    host_on  = 1'b1;
    host_pct = 15;
    wait_idle();

    test_name           = "back_pressure";
    host_on             = 1'b0;
    base                = issued;
    push_pct[src_write] = 100;
    repeat (16) @(posedge clock);
    push_pct[src_write] = 0;
    repeat (10) @(posedge clock);
    if (issued - base != max_credits) begin
      report_mismatch("issued with full credits", max_credits, issued - base);
    end
    base = issued;
    repeat (20) @(posedge clock);
    if (issued != base) begin
      report_mismatch("issued without credits", 0, issued - base);
    end
    respond_once = 1'b1;
    repeat (10) @(posedge clock);
    if (issued - base != 1) begin
      report_mismatch("issued after one response", 1, issued - base);
    end
    wait_idle();

    test_name = "response_codes";
    push_pct  = '{60, 60, 60, 60};
    host_pct  = 100;
    repeat (200) @(posedge clock);
    wait_idle();

    test_name          = "full_flag";
    host_on            = 1'b0;
    push_pct[src_read] = 100;
    repeat (20) @(posedge clock);
    push_pct[src_read] = 0;
    @(negedge clock);
    if (full != 4'b0100) begin
      report_mismatch("full vector", 4'b0100, full);
    end
    wait_idle();

    $display("Run finished: %0d commands issued, %0d errors", issued, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
src/capi_cmd_pkg.sv
src/command_queue.sv
src/command_buffer_arbiter.sv
src/credit_tracker.sv
src/response_decoder.sv
src/command_control.sv
verif/command_control_sva.sv
verif/tb_command_control.sv

// ==== Bender.yml ====
package:
  name: command_control

sources:
  - src/capi_cmd_pkg.sv
  - src/command_queue.sv
  - src/command_buffer_arbiter.sv
  - src/credit_tracker.sv
  - src/response_decoder.sv
  - src/command_control.sv
  - target: simulation
    files:
      - verif/command_control_sva.sv
      - verif/tb_command_control.sv
